// File: verilog/fetch_pkg.sv
package fetch_pkg;

	// Data path and tag sizes
	localparam int xlen = 32;
	localparam int tag_width = 8;

	// Instruction cache geometry
	localparam int line_words = 4;
	localparam int cache_lines = 16;
	localparam int word_sel_width = $clog2(line_words);
	localparam int cache_offset_width = word_sel_width + 2;
	localparam int cache_index_width = $clog2(cache_lines);
	localparam int cache_tag_width = xlen - cache_index_width - cache_offset_width;

	// Instruction queue
	localparam int queue_depth = 4;
	localparam int queue_ptr_width = $clog2(queue_depth);
	localparam int queue_count_width = $clog2(queue_depth + 1);

	localparam logic [xlen-1:0] reset_pc = '0;

	// RV32 opcodes of interest to fetch
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_system = 7'b1110011;

	// SYSTEM immediates
	localparam logic [11:0] funct_mret = 12'h302;
	localparam logic [11:0] funct_wfi = 12'h105;

	typedef enum logic [2:0] {
		cls_sequential,
		cls_jump,
		cls_jump_register,
		cls_branch,
		cls_mret,
		cls_wfi
	} instr_class_t;

	function automatic instr_class_t classify(input logic [xlen-1:0] instr);
		instr_class_t cls;
		cls = cls_sequential;
		case (instr[6:0])
			op_jal: cls = cls_jump;
			op_jalr: cls = cls_jump_register;
			op_branch: cls = cls_branch;
			op_system: begin
				// Only PRIV encodings with funct3 zero
				if (instr[14:12] == 3'b000 && instr[31:20] == funct_mret) begin
					cls = cls_mret;
				end else if (instr[14:12] == 3'b000 && instr[31:20] == funct_wfi) begin
					cls = cls_wfi;
				end
			end
			default: cls = cls_sequential;
		endcase
		return cls;
	endfunction

endpackage

// File: verilog/fetch_icache.sv
module fetch_icache (
	input  logic                      i_clock,
	input  logic                      i_rst,
	input  logic [fetch_pkg::xlen-1:0] i_pc,
	input  logic                      i_hold,
	input  logic [fetch_pkg::xlen-1:0] i_wb_dat,
	input  logic                      i_wb_ack,
	output logic                      o_ready,
	output logic [fetch_pkg::xlen-1:0] o_rdata,
	output logic                      o_wb_cyc,
	output logic                      o_wb_stb,
	output logic                      o_wb_we,
	output logic [fetch_pkg::xlen-1:0] o_wb_adr
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		ic_idle,
		ic_request,
		ic_gap
	} fill_state_t;

	logic [cache_lines-1:0] line_valid;
	logic [cache_tag_width-1:0] line_tag [cache_lines];
	logic [xlen-1:0] line_data [cache_lines*line_words];

	logic [word_sel_width-1:0] pc_word;
	logic [cache_index_width-1:0] pc_index;
	logic [cache_tag_width-1:0] pc_tag;

	fill_state_t fill_state;
	logic [xlen-cache_offset_width-1:0] fill_line;
	logic [cache_index_width-1:0] fill_index;
	logic [word_sel_width-1:0] fill_word;
	logic fill_start;
	logic word_ack;

	// Address split of the requested pc
	assign pc_word = i_pc[cache_offset_width-1:2];
	assign pc_index = i_pc[cache_offset_width +: cache_index_width];
	assign pc_tag = i_pc[xlen-1 -: cache_tag_width];

	// Hit path is purely combinational
	assign o_ready = line_valid[pc_index] && (line_tag[pc_index] == pc_tag);
	assign o_rdata = line_data[{pc_index, pc_word}];

	assign fill_index = fill_line[cache_index_width-1:0];
	assign fill_start = (fill_state == ic_idle) && !o_ready && !i_hold;
	assign word_ack = (fill_state == ic_request) && i_wb_ack;

	assign o_wb_adr = {fill_line, fill_word, 2'b00};
	assign o_wb_we = 1'b0;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			fill_state <= ic_idle;
			fill_word <= '0;
			line_valid <= '0;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end else begin
			case (fill_state)
				ic_idle: begin
					if (fill_start) begin
						// Line gets replaced, so drop it before the first word lands
						line_valid[pc_index] <= 1'b0;
						fill_word <= '0;
						o_wb_cyc <= 1'b1;
						o_wb_stb <= 1'b1;
						fill_state <= ic_request;
					end
				end
				ic_request: begin
					if (i_wb_ack) begin
						o_wb_cyc <= 1'b0;
						o_wb_stb <= 1'b0;
						if (fill_word == word_sel_width'(line_words - 1)) begin
							line_valid[fill_index] <= 1'b1;
							fill_state <= ic_idle;
						end else begin
							fill_word <= fill_word + 1'b1;
							fill_state <= ic_gap;
						end
					end
				end
				ic_gap: begin
					// Bus idle for one cycle between single reads
					o_wb_cyc <= 1'b1;
					o_wb_stb <= 1'b1;
					fill_state <= ic_request;
				end
				default: fill_state <= ic_idle;
			endcase
		end
	end

	// Tag and word storage
	always_ff @(posedge i_clock) begin
		if (fill_start) begin
			fill_line <= i_pc[xlen-1:cache_offset_width];
			line_tag[pc_index] <= pc_tag;
		end
		if (word_ack) begin
			line_data[{fill_index, fill_word}] <= i_wb_dat;
		end
	end

	a_stb_needs_cyc: assert property (
		@(posedge i_clock) disable iff (i_rst)
		o_wb_stb |-> o_wb_cyc
	);

	// Slave sees a fixed address until it acknowledges
	a_adr_stable: assert property (
		@(posedge i_clock) disable iff (i_rst)
		o_wb_stb && !i_wb_ack |=> $stable(o_wb_adr)
	);

endmodule

// File: verilog/fetch_unit.sv
module fetch_unit (
	input  logic                           i_clock,
	input  logic                           i_rst,
	input  logic                           i_irq,
	input  logic [fetch_pkg::xlen-1:0]      i_irq_pc,
	input  logic                           i_jump,
	input  logic [fetch_pkg::xlen-1:0]      i_jump_pc,
	input  logic                           i_q_full,
	input  logic [fetch_pkg::xlen-1:0]      i_wb_dat,
	input  logic                           i_wb_ack,
	output logic                           o_q_push,
	output logic [fetch_pkg::xlen-1:0]      o_q_instr,
	output logic [fetch_pkg::xlen-1:0]      o_q_pc,
	output logic [fetch_pkg::tag_width-1:0] o_q_tag,
	output logic                           o_irq_taken,
	output logic [fetch_pkg::xlen-1:0]      o_irq_epc,
	output logic                           o_wb_cyc,
	output logic                           o_wb_stb,
	output logic                           o_wb_we,
	output logic [fetch_pkg::xlen-1:0]      o_wb_adr
);
	import fetch_pkg::*;

	typedef enum logic {
		st_fetch,
		st_wait
	} fetch_state_t;

	fetch_state_t state;
	logic [xlen-1:0] pc;
	logic wait_on_wfi;
	logic cache_ready;
	logic cache_hold;
	logic [xlen-1:0] cache_rdata;
	instr_class_t fetched_class;
	logic push_now;

	// No new line fills while parked on a control-flow instruction
	assign cache_hold = (state == st_wait);
	assign fetched_class = classify(cache_rdata);
	assign push_now = !i_irq && (state == st_fetch) && cache_ready && !i_q_full;

	fetch_icache icache_i (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_pc    (pc),
		.i_hold  (cache_hold),
		.i_wb_dat(i_wb_dat),
		.i_wb_ack(i_wb_ack),
		.o_ready (cache_ready),
		.o_rdata (cache_rdata),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_we (o_wb_we),
		.o_wb_adr(o_wb_adr)
	);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= st_fetch;
			pc <= reset_pc;
			wait_on_wfi <= 1'b0;
			o_q_push <= 1'b0;
			o_q_tag <= '0;
			o_irq_taken <= 1'b0;
		end else begin
			o_q_push <= 1'b0;
			o_irq_taken <= 1'b0;
			if (i_irq) begin
				// Interrupt wins over both states
				o_irq_taken <= 1'b1;
				pc <= i_irq_pc;
				state <= st_fetch;
				wait_on_wfi <= 1'b0;
			end else begin
				case (state)
					st_fetch: begin
						if (push_now) begin
							o_q_push <= 1'b1;
							o_q_tag <= o_q_tag + 1'b1;
							if (fetched_class == cls_sequential) begin
								pc <= pc + xlen'(4);
							end else begin
								state <= st_wait;
								wait_on_wfi <= (fetched_class == cls_wfi);
							end
						end
					end
					st_wait: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= st_fetch;
						end
					end
					default: state <= st_fetch;
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (push_now) begin
			o_q_instr <= cache_rdata;
			o_q_pc <= pc;
		end
		// After WFI, resume at the following instruction
		if (i_irq) begin
			o_irq_epc <= (state == st_wait && wait_on_wfi) ? pc + xlen'(4) : pc;
		end
	end

	// Full seen in one cycle blocks the push of the next
	a_no_push_when_full: assert property (
		@(posedge i_clock) disable iff (i_rst)
		i_q_full |=> !o_q_push
	);

endmodule

// File: verilog/instr_queue.sv
module instr_queue (
	input  logic                           i_clock,
	input  logic                           i_rst,
	input  logic                           i_flush,
	input  logic                           i_push,
	input  logic [fetch_pkg::xlen-1:0]      i_instr,
	input  logic [fetch_pkg::xlen-1:0]      i_pc,
	input  logic [fetch_pkg::tag_width-1:0] i_tag,
	input  logic                           i_pop,
	output logic                           o_full,
	output logic                           o_valid,
	output logic [fetch_pkg::xlen-1:0]      o_instr,
	output logic [fetch_pkg::xlen-1:0]      o_pc,
	output logic [fetch_pkg::tag_width-1:0] o_tag
);
	import fetch_pkg::*;

	logic [xlen-1:0] instr_mem [queue_depth];
	logic [xlen-1:0] pc_mem [queue_depth];
	logic [tag_width-1:0] tag_mem [queue_depth];
	logic [queue_ptr_width-1:0] wr_ptr;
	logic [queue_ptr_width-1:0] rd_ptr;
	logic [queue_count_width-1:0] count;
	logic [queue_count_width-1:0] count_next;
	logic do_push;
	logic do_pop;

	assign o_valid = (count != '0);
	assign do_push = i_push && (count != queue_count_width'(queue_depth));
	assign do_pop = i_pop && o_valid;

	always_comb begin
		if (i_flush) begin
			count_next = '0;
		end else begin
			count_next = count + queue_count_width'(do_push) - queue_count_width'(do_pop);
		end
	end

	// Looks one cycle ahead since the producer pushes a cycle after it decides
	assign o_full = (count_next == queue_count_width'(queue_depth));

	assign o_instr = instr_mem[rd_ptr];
	assign o_pc = pc_mem[rd_ptr];
	assign o_tag = tag_mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (i_rst || i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count_next;
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_push) begin
			instr_mem[wr_ptr] <= i_instr;
			pc_mem[wr_ptr] <= i_pc;
			tag_mem[wr_ptr] <= i_tag;
		end
	end

	a_no_overflow: assert property (
		@(posedge i_clock) disable iff (i_rst)
		i_push |-> count != queue_count_width'(queue_depth)
	);

	a_no_underflow: assert property (
		@(posedge i_clock) disable iff (i_rst)
		i_pop |-> count != '0
	);

endmodule

// File: verilog/branch_resolver.sv
module branch_resolver (
	input  logic                           i_clock,
	input  logic                           i_rst,
	input  logic                           i_valid,
	input  logic [fetch_pkg::xlen-1:0]      i_instr,
	input  logic [fetch_pkg::xlen-1:0]      i_pc,
	input  logic [fetch_pkg::tag_width-1:0] i_tag,
	input  logic                           i_irq_taken,
	input  logic [fetch_pkg::xlen-1:0]      i_irq_epc,
	output logic                           o_pop,
	output logic                           o_jump,
	output logic [fetch_pkg::xlen-1:0]      o_jump_pc,
	output logic                           o_retire_valid,
	output logic [fetch_pkg::xlen-1:0]      o_retire_pc,
	output logic [fetch_pkg::xlen-1:0]      o_retire_instr,
	output logic [fetch_pkg::tag_width-1:0] o_retire_tag
);
	import fetch_pkg::*;

	instr_class_t entry_class;
	logic [xlen-1:0] imm_j;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] target;
	logic [xlen-1:0] saved_epc;
	logic redirect;

	// Consume whatever the queue offers
	assign o_pop = i_valid;
	assign entry_class = classify(i_instr);

	assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
	assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};

	always_comb begin
		target = i_pc + xlen'(4);
		redirect = 1'b1;
		case (entry_class)
			cls_jump: target = i_pc + imm_j;
			// rs1 taken as zero
			cls_jump_register: target = imm_i & ~xlen'(1);
			cls_branch: begin
				// Static rule takes backward branches only
				if (imm_b[xlen-1]) begin
					target = i_pc + imm_b;
				end
			end
			cls_mret: target = saved_epc;
			default: redirect = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_retire_valid <= 1'b0;
			o_jump <= 1'b0;
		end else begin
			o_retire_valid <= i_valid;
			// Redirect goes stale once fetch has been sent to the vector
			o_jump <= i_valid && redirect && !i_irq_taken;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_retire_pc <= i_pc;
			o_retire_instr <= i_instr;
			o_retire_tag <= i_tag;
			o_jump_pc <= target;
		end
		if (i_irq_taken) begin
			saved_epc <= i_irq_epc;
		end
	end

endmodule

// File: verilog/fetch_top.sv
module fetch_top (
	input  logic                           i_clock,
	input  logic                           i_rst,
	input  logic                           i_irq,
	input  logic [fetch_pkg::xlen-1:0]      i_irq_pc,
	input  logic [fetch_pkg::xlen-1:0]      i_wb_dat,
	input  logic                           i_wb_ack,
	output logic                           o_wb_cyc,
	output logic                           o_wb_stb,
	output logic                           o_wb_we,
	output logic [fetch_pkg::xlen-1:0]      o_wb_adr,
	output logic                           o_irq_ack,
	output logic [fetch_pkg::xlen-1:0]      o_irq_epc,
	output logic                           o_retire_valid,
	output logic [fetch_pkg::xlen-1:0]      o_retire_pc,
	output logic [fetch_pkg::xlen-1:0]      o_retire_instr,
	output logic [fetch_pkg::tag_width-1:0] o_retire_tag
);
	import fetch_pkg::*;

	// Fetch to queue
	logic q_push;
	logic [xlen-1:0] q_instr;
	logic [xlen-1:0] q_pc;
	logic [tag_width-1:0] q_tag;
	logic q_full;

	// Queue to resolver
	logic q_valid;
	logic q_pop;
	logic [xlen-1:0] q_out_instr;
	logic [xlen-1:0] q_out_pc;
	logic [tag_width-1:0] q_out_tag;

	logic jump;
	logic [xlen-1:0] jump_pc;
	logic irq_taken;
	logic [xlen-1:0] irq_epc;

	assign o_irq_ack = irq_taken;
	assign o_irq_epc = irq_epc;

	fetch_unit fetch_unit_i (
		.i_clock    (i_clock),
		.i_rst      (i_rst),
		.i_irq      (i_irq),
		.i_irq_pc   (i_irq_pc),
		.i_jump     (jump),
		.i_jump_pc  (jump_pc),
		.i_q_full   (q_full),
		.i_wb_dat   (i_wb_dat),
		.i_wb_ack   (i_wb_ack),
		.o_q_push   (q_push),
		.o_q_instr  (q_instr),
		.o_q_pc     (q_pc),
		.o_q_tag    (q_tag),
		.o_irq_taken(irq_taken),
		.o_irq_epc  (irq_epc),
		.o_wb_cyc   (o_wb_cyc),
		.o_wb_stb   (o_wb_stb),
		.o_wb_we    (o_wb_we),
		.o_wb_adr   (o_wb_adr)
	);

	// Interrupt throws away everything fetched before it
	instr_queue instr_queue_i (
		.i_clock(i_clock),
		.i_rst  (i_rst),
		.i_flush(irq_taken),
		.i_push (q_push),
		.i_instr(q_instr),
		.i_pc   (q_pc),
		.i_tag  (q_tag),
		.i_pop  (q_pop),
		.o_full (q_full),
		.o_valid(q_valid),
		.o_instr(q_out_instr),
		.o_pc   (q_out_pc),
		.o_tag  (q_out_tag)
	);

	branch_resolver branch_resolver_i (
		.i_clock       (i_clock),
		.i_rst         (i_rst),
		.i_valid       (q_valid),
		.i_instr       (q_out_instr),
		.i_pc          (q_out_pc),
		.i_tag         (q_out_tag),
		.i_irq_taken   (irq_taken),
		.i_irq_epc     (irq_epc),
		.o_pop         (q_pop),
		.o_jump        (jump),
		.o_jump_pc     (jump_pc),
		.o_retire_valid(o_retire_valid),
		.o_retire_pc   (o_retire_pc),
		.o_retire_instr(o_retire_instr),
		.o_retire_tag  (o_retire_tag)
	);

endmodule

// File: tests/wb_mem_model.sv
module wb_mem_model #(
	parameter int depth_words = 64
) (
	input  logic        i_clock,
	input  logic        i_rst,
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic [31:0] i_wb_adr,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int index_width = $clog2(depth_words);

	logic [31:0] mem [depth_words];
	logic busy;
	int unsigned wait_left;
	logic next_ack;
	logic [31:0] next_dat;

	// Classic slave with one read per strobe and 0 to 3 wait cycles
	initial begin
		o_wb_ack = 1'b0;
		o_wb_dat = '0;
		busy = 1'b0;
		wait_left = 0;
		forever begin
			@(negedge i_clock);
			next_ack = 1'b0;
			next_dat = o_wb_dat;
			if (i_rst) begin
				busy = 1'b0;
			end else if (i_wb_cyc && i_wb_stb && !o_wb_ack) begin
				if (!busy) begin
					busy = 1'b1;
					wait_left = $urandom % 4;
				end
				if (wait_left == 0) begin
					next_ack = 1'b1;
					next_dat = mem[i_wb_adr[2 +: index_width]];
					busy = 1'b0;
				end else begin
					wait_left = wait_left - 1;
				end
			end
			// Outputs change just after the edge
			@(posedge i_clock);
			#2;
			o_wb_ack = next_ack;
			o_wb_dat = next_dat;
		end
	end

endmodule

// File: tests/fetch_tb.sv
module fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;

	localparam int half_period = 20;
	localparam int reset_cycles = 8;
	localparam int mem_words = 64;
	localparam int cycles_per_retire = 200;
	localparam int expected_irqs = 4;

	// Program layout
	localparam logic [31:0] irq_trigger_pc = 32'h008;
	localparam logic [31:0] wfi_mid_pc = 32'h08C;
	localparam logic [31:0] wfi_end_pc = 32'h09C;
	localparam logic [31:0] handler_a_pc = 32'h0A0;
	localparam logic [31:0] handler_a_end = 32'h0A8;
	localparam logic [31:0] handler_b_pc = 32'h0C0;
	localparam logic [31:0] handler_b_end = 32'h0CC;
	localparam logic [31:0] mret_word = 32'h30200073;
	localparam logic [31:0] wfi_word = 32'h10500073;

	logic i_clock;
	logic i_rst;
	logic i_irq;
	logic [31:0] i_irq_pc;
	logic [31:0] i_wb_dat;
	logic i_wb_ack;
	logic o_wb_cyc;
	logic o_wb_stb;
	logic o_wb_we;
	logic [31:0] o_wb_adr;
	logic o_irq_ack;
	logic [31:0] o_irq_epc;
	logic o_retire_valid;
	logic [31:0] o_retire_pc;
	logic [31:0] o_retire_instr;
	logic [tag_width-1:0] o_retire_tag;

	logic [31:0] prog [mem_words];
	int errors = 0;
	int checks = 0;
	int retired = 0;
	int expected_total = 0;
	int bus_reads = 0;
	int second_pass_reads = 0;
	int fills = 0;
	int irq_acks = 0;
	logic [31:0] expected_pc = reset_pc;
	logic [31:0] saved_epc = '0;
	logic [31:0] irq_target = '0;
	logic [tag_width-1:0] last_tag = '0;
	logic irq_wanted = 1'b0;
	logic irq_pending = 1'b0;
	logic second_pass = 1'b0;
	logic finished = 1'b0;
	logic [1:0] fill_word = '0;
	logic [27:0] fill_base = '0;
	logic [mem_words/4-1:0] lines_seen = '0;

	fetch_top fetch_top_i (
		.i_clock       (i_clock),
		.i_rst         (i_rst),
		.i_irq         (i_irq),
		.i_irq_pc      (i_irq_pc),
		.i_wb_dat      (i_wb_dat),
		.i_wb_ack      (i_wb_ack),
		.o_wb_cyc      (o_wb_cyc),
		.o_wb_stb      (o_wb_stb),
		.o_wb_we       (o_wb_we),
		.o_wb_adr      (o_wb_adr),
		.o_irq_ack     (o_irq_ack),
		.o_irq_epc     (o_irq_epc),
		.o_retire_valid(o_retire_valid),
		.o_retire_pc   (o_retire_pc),
		.o_retire_instr(o_retire_instr),
		.o_retire_tag  (o_retire_tag)
	);

	wb_mem_model #(
		.depth_words(mem_words)
	) mem_i (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_wb_cyc(o_wb_cyc),
		.i_wb_stb(o_wb_stb),
		.i_wb_adr(o_wb_adr),
		.o_wb_dat(i_wb_dat),
		.o_wb_ack(i_wb_ack)
	);

	initial begin
		i_clock = 1'b0;
		forever #half_period i_clock = ~i_clock;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: %s is %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic print_counts();
		$display("checks %0d, errors %0d, retired %0d of %0d, bus reads %0d, line fills %0d",
			checks, errors, retired, expected_total, bus_reads, fills);
	endtask

	// Encoders with rd and rs fields all zero
	function automatic logic [31:0] jal_word(input logic [31:0] offset);
		return {offset[20], offset[10:1], offset[11], offset[19:12], 5'd0, 7'b1101111};
	endfunction

	function automatic logic [31:0] branch_word(input logic [31:0] offset);
		return {offset[12], offset[10:5], 10'd0, 3'b000, offset[4:1], offset[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jalr_word(input logic [31:0] target);
		return {target[11:0], 5'd0, 3'b000, 5'd0, 7'b1100111};
	endfunction

	// Random OP-IMM word that is never control flow
	function automatic logic [31:0] seq_word();
		logic [31:0] bits;
		bits = $urandom;
		return {bits[31:7], 7'b0010011};
	endfunction

	// Static rules of the resolver
	function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] instr,
			input logic [31:0] epc);
		logic [31:0] offset;
		logic [31:0] target;
		target = pc + 32'd4;
		case (instr[6:0])
			7'b1101111: begin
				offset = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
				target = pc + offset;
			end
			7'b1100111: target = {{20{instr[31]}}, instr[31:20]} & 32'hFFFF_FFFE;
			7'b1100011: begin
				offset = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
				if (offset[31]) begin
					target = pc + offset;
				end
			end
			7'b1110011: begin
				if (instr == mret_word) begin
					target = epc;
				end
			end
			default: target = pc + 32'd4;
		endcase
		return target;
	endfunction

	// Also marks every cache line that the walk passes through
	function automatic int trace_length(input logic [31:0] start, input logic [31:0] last);
		logic [31:0] pc;
		int steps;
		pc = start;
		steps = 1;
		lines_seen[pc[7:4]] = 1'b1;
		while (pc != last && steps < mem_words * 4) begin
			pc = next_pc(pc, prog[pc[7:2]], '0);
			lines_seen[pc[7:4]] = 1'b1;
			steps++;
		end
		return steps;
	endfunction

	task automatic place(input logic [31:0] addr, input logic [31:0] word);
		prog[addr[7:2]] = word;
	endtask

	// Backward branch lands on a pad that jumps past it, so it is taken once
	task automatic build_program();
		for (int i = 0; i < mem_words; i++) begin
			prog[i] = seq_word();
		end
		place(32'h030, jal_word(32'h10));
		place(32'h03C, jal_word(32'h20));
		place(32'h050, branch_word(32'h10));
		place(32'h058, branch_word(32'hFFFF_FFDC));
		place(32'h064, jalr_word(32'h080));
		place(wfi_mid_pc, wfi_word);
		place(wfi_end_pc, wfi_word);
		place(handler_a_end, mret_word);
		place(handler_b_end, mret_word);
		for (int i = 0; i < mem_words; i++) begin
			mem_i.mem[i] = prog[i];
		end
	endtask

	task automatic request_irq(input logic [31:0] vector);
		irq_target = vector;
		irq_wanted = 1'b1;
	endtask

	task automatic retire_check();
		logic [31:0] instr;
		logic [tag_width-1:0] tag_next;
		// Interrupted stream has drained and its next pc is the reported one
		if (irq_pending && o_retire_pc == irq_target) begin
			check_value("o_irq_epc", o_irq_epc, expected_pc);
			saved_epc = expected_pc;
			expected_pc = irq_target;
			irq_pending = 1'b0;
		end
		instr = prog[expected_pc[7:2]];
		tag_next = last_tag + 1'b1;
		check_value("o_retire_pc", o_retire_pc, expected_pc);
		check_value("o_retire_instr", o_retire_instr, instr);
		if (retired > 0) begin
			check_value("o_retire_tag", o_retire_tag, tag_next);
		end
		last_tag = o_retire_tag;
		retired++;
		if (!second_pass && expected_pc == irq_trigger_pc) begin
			request_irq(handler_a_pc);
		end else if (expected_pc == wfi_mid_pc) begin
			request_irq(handler_b_pc);
		end else if (expected_pc == wfi_end_pc) begin
			if (second_pass) begin
				finished = 1'b1;
			end else begin
				// Rerun the whole program from the cache
				second_pass = 1'b1;
				request_irq(reset_pc);
			end
		end
		expected_pc = next_pc(expected_pc, instr, saved_epc);
	endtask

	always @(negedge i_clock) begin
		if (!i_rst) begin
			if (o_irq_ack) begin
				irq_pending = 1'b1;
				irq_acks++;
			end
			if (o_retire_valid) begin
				retire_check();
			end
		end
	end

	// Bus monitor
	always @(negedge i_clock) begin
		if (!i_rst) begin
			if (o_wb_cyc || o_wb_stb) begin
				check_value("o_wb_stb", o_wb_stb, o_wb_cyc);
				check_value("o_wb_we", o_wb_we, 1'b0);
				check_value("o_wb_adr[1:0]", o_wb_adr[1:0], 2'b00);
			end
			if (o_wb_stb && i_wb_ack) begin
				bus_reads++;
				if (second_pass) begin
					second_pass_reads++;
				end
				if (fill_word == 2'd0) begin
					fill_base = o_wb_adr[31:4];
				end
				check_value("o_wb_adr", o_wb_adr, {fill_base, fill_word, 2'b00});
				check_value("o_wb_adr[31:8]", o_wb_adr[31:8], '0);
				fill_word = fill_word + 2'd1;
				if (fill_word == 2'd0) begin
					fills++;
				end
			end
		end
	end

	initial begin
		void'($urandom(32838));
		i_rst = 1'b1;
		i_irq = 1'b0;
		i_irq_pc = '0;
		build_program();
		expected_total = 2 * trace_length(reset_pc, wfi_end_pc)
			+ trace_length(handler_a_pc, handler_a_end)
			+ 2 * trace_length(handler_b_pc, handler_b_end);
		repeat (reset_cycles - 1) @(posedge i_clock);
		@(negedge i_clock);
		check_value("o_retire_valid", o_retire_valid, 1'b0);
		check_value("o_wb_cyc", o_wb_cyc, 1'b0);
		check_value("o_wb_stb", o_wb_stb, 1'b0);
		check_value("o_irq_ack", o_irq_ack, 1'b0);
		@(posedge i_clock);
		#2;
		i_rst = 1'b0;
		while (!finished) begin
			@(posedge i_clock);
			if (irq_wanted) begin
				irq_wanted = 1'b0;
				#2;
				i_irq = 1'b1;
				i_irq_pc = irq_target;
				@(posedge i_clock);
				#2;
				i_irq = 1'b0;
			end
		end
		repeat (4) @(posedge i_clock);
		if (retired != expected_total) begin
			errors++;
			$display("retired %0d instructions instead of %0d", retired, expected_total);
		end
		if (fill_word != 2'd0) begin
			errors++;
			$display("a line fill stopped after %0d reads", fill_word);
		end
		if (fills != $countones(lines_seen)) begin
			errors++;
			$display("saw %0d line fills instead of %0d", fills, $countones(lines_seen));
		end
		if (second_pass_reads != 0) begin
			errors++;
			$display("second pass over cached code issued %0d bus reads", second_pass_reads);
		end
		if (irq_acks != expected_irqs) begin
			errors++;
			$display("saw %0d interrupt acknowledges instead of %0d", irq_acks, expected_irqs);
		end
		print_counts();
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (expected_total > 0);
		repeat (cycles_per_retire * expected_total) @(posedge i_clock);
		errors++;
		$display("timeout: run did not finish within %0d cycles",
			cycles_per_retire * expected_total);
		print_counts();
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: filelist.f
verilog/fetch_pkg.sv
verilog/fetch_icache.sv
verilog/fetch_unit.sv
verilog/instr_queue.sv
verilog/branch_resolver.sv
verilog/fetch_top.sv
tests/wb_mem_model.sv
tests/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_icache.sv
      - verilog/fetch_unit.sv
      - verilog/instr_queue.sv
      - verilog/branch_resolver.sv
      - verilog/fetch_top.sv
  - target: test
    files:
      - tests/wb_mem_model.sv
      - tests/fetch_tb.sv
